/* logic/rx_params.svh */
// field positions assume the 256-bit CQ descriptor layout; the window default suits simulation only
`ifndef RX_PARAMS_SVH
`define RX_PARAMS_SVH

//////////////////// stream and word sizes
`define RX_DATA_W      256   // CQ tdata and FIFO word
`define RX_DW_W        32
`define RX_LEN_W       11    // dw count field
`define RX_ADDR_W      11    // memory word address
`define RX_TUSER_W     85
`define RX_TKEEP_W     8     // one keep bit per dw, also dw lanes per FIFO word
`define RX_THRU_WINDOW 64    // cycles per throughput window
`define RX_CNT_W       32

//////////////////// descriptor fields, header beat
`define RX_LEN_MSB     74
`define RX_LEN_LSB     64
`define RX_TYPE_MSB    78
`define RX_TYPE_LSB    75
`define RX_RID_MSB     95
`define RX_RID_LSB     80
`define RX_TAG_MSB     103
`define RX_TAG_LSB     96
`define RX_TC_MSB      123
`define RX_TC_LSB      121
`define RX_ATTR_MSB    126
`define RX_ATTR_LSB    124
`define RX_ADDR_MSB    12    // dw address, byte offset bits dropped
`define RX_ADDR_LSB    2
`define RX_BE_MSB      7     // these two index tuser
`define RX_BE_LSB      0

// derived field widths
`define RX_TYPE_W      (`RX_TYPE_MSB - `RX_TYPE_LSB + 1)
`define RX_RID_W       (`RX_RID_MSB - `RX_RID_LSB + 1)
`define RX_TAG_W       (`RX_TAG_MSB - `RX_TAG_LSB + 1)
`define RX_TC_W        (`RX_TC_MSB - `RX_TC_LSB + 1)
`define RX_ATTR_W      (`RX_ATTR_MSB - `RX_ATTR_LSB + 1)
`define RX_BE_W        (`RX_BE_MSB - `RX_BE_LSB + 1)

`endif

/* logic/rx_pkg.sv */
// request types other than memory read and write fall outside the enum and are dropped by the engine
`default_nettype none

`include "rx_params.svh"

package rx_pkg;

   //////////////////// request type field
   typedef enum logic [`RX_TYPE_W-1:0] {
      REQ_MEM_RD = 4'd0,   // only one dw reads get a completion
      REQ_MEM_WR = 4'd1    // any length, packed into FIFO words
   } req_type_e;

   //////////////////// header beat descriptor
   // 64 bits, filled by decode from tdata and tuser
   typedef struct packed {
      req_type_e                req_type;
      logic [`RX_LEN_W-1:0]     len;    // payload dws
      logic [`RX_ADDR_W-1:0]    addr;   // dw address
      logic [`RX_RID_W-1:0]     rid;    // requester id
      logic [`RX_TAG_W-1:0]     tag;
      logic [`RX_TC_W-1:0]      tc;     // traffic class
      logic [`RX_ATTR_W-1:0]    attr;
      logic [`RX_BE_W-1:0]      be;     // first and last dw byte enables
   } cq_desc_t;

endpackage

`default_nettype wire

/* logic/cq_hdr_if.sv */
// all signals are combinational from the accepted beat; desc holds meaning only while sop is high
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

interface cq_hdr_if
   import rx_pkg::*;
();

   logic                  sop;    // header beat taken this cycle
   logic                  beat;   // payload beat taken this cycle
   logic                  last;   // taken beat ends its packet
   cq_desc_t              desc;
   logic [`RX_DATA_W-1:0] data;   // raw beat

   // decode drives, execute side only listens
   modport src (output sop, beat, last, desc, data);
   modport rd  (input sop, desc);                      // reads never carry payload
   modport wr  (input sop, beat, last, desc, data);

endinterface

`default_nettype wire

/* logic/cq_decode.sv */
// assumes tlast marks every packet end; tready drops one cycle after any hold or flush request
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

module cq_decode
   import rx_pkg::*;
(
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire [`RX_DATA_W-1:0]    cq_tdata_i,
   input  wire                     cq_tvalid_i,
   input  wire                     cq_tlast_i,
   input  wire [`RX_TUSER_W-1:0]   cq_tuser_i,
   output logic                    cq_tready_o,
   input  wire                     rd_hold_i,    // read waits on its completion
   input  wire                     wr_flush_i,   // packer needs a spare cycle
   cq_hdr_if.src                   hdr
);

   logic     in_pkt_q;   // header seen, tlast not yet
   logic     tready_q;
   logic     accept;     // beat moves this cycle
   cq_desc_t desc;

   assign accept      = cq_tvalid_i & tready_q;   // both sides, not valid alone
   assign cq_tready_o = tready_q;

   //////////////////// packet tracking
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt_q <= 1'b0;
      end else if (accept && cq_tlast_i) begin
         in_pkt_q <= 1'b0;                        // closes, next beat is a header
      end else if (accept) begin
         in_pkt_q <= 1'b1;
      end
   end

   // ready is a register, one stall cycle per request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tready_q <= 1'b1;
      end else begin
         tready_q <= ~(rd_hold_i | wr_flush_i);
      end
   end

   //////////////////// header fields
   always_comb begin
      desc.req_type = req_type_e'(cq_tdata_i[`RX_TYPE_MSB:`RX_TYPE_LSB]);
      desc.len      = cq_tdata_i[`RX_LEN_MSB:`RX_LEN_LSB];
      desc.addr     = cq_tdata_i[`RX_ADDR_MSB:`RX_ADDR_LSB];  // dw address
      desc.rid      = cq_tdata_i[`RX_RID_MSB:`RX_RID_LSB];
      desc.tag      = cq_tdata_i[`RX_TAG_MSB:`RX_TAG_LSB];
      desc.tc       = cq_tdata_i[`RX_TC_MSB:`RX_TC_LSB];
      desc.attr     = cq_tdata_i[`RX_ATTR_MSB:`RX_ATTR_LSB];
      desc.be       = cq_tuser_i[`RX_BE_MSB:`RX_BE_LSB];      // from tuser, not tdata
   end

   // no register stage towards execute
   assign hdr.sop  = accept & ~in_pkt_q;
   assign hdr.beat = accept & in_pkt_q;
   assign hdr.last = accept & cq_tlast_i;
   assign hdr.desc = desc;
   assign hdr.data = cq_tdata_i;

endmodule

`default_nettype wire

/* logic/mem_rd_request.sv */
// only one dw reads are served; other lengths pass through with no request and no stall
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

module mem_rd_request
   import rx_pkg::*;
(
   input  wire     clk,
   input  wire     rst_n,
   cq_hdr_if.rd    hdr,
   input  wire     compl_done_i,   // completion sent by transmit side
   output logic    req_compl_o,
   output cq_desc_t req_desc_o,
   output logic    rd_hold_o
);

   logic rd_start;   // one dw read header taken

   assign rd_start = hdr.sop
                     && (hdr.desc.req_type == REQ_MEM_RD)
                     && (hdr.desc.len == `RX_LEN_W'(1));

   //////////////////// request level
   // rises after the header, falls on the edge after done
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_compl_o <= 1'b0;
      end else if (rd_start) begin
         req_compl_o <= 1'b1;
      end else if (req_compl_o && compl_done_i) begin
         req_compl_o <= 1'b0;
      end
   end

   // descriptor stays put while the request is open
   always_ff @(posedge clk) begin
      if (rd_start) begin
         req_desc_o <= hdr.desc;
      end
   end

   // covers the header cycle too, so tready is low right from the next edge
   // and comes back on the same edge the request falls
   assign rd_hold_o = rd_start | (req_compl_o & ~compl_done_i);

endmodule

`default_nettype wire

/* logic/mem_wr_packer.sv */
// FIFO has no back-pressure; a write length of zero is not handled as 1024 dws
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

module mem_wr_packer
   import rx_pkg::*;
(
   input  wire                     clk,
   input  wire                     rst_n,
   cq_hdr_if.wr                    hdr,
   output logic [`RX_DATA_W-1:0]   fifo_wr_data_o,
   output logic                    fifo_wr_en_o,
   output logic                    pkt_done_o,
   output logic                    wr_flush_o
);

   localparam int HALF_W = `RX_DATA_W / 2;   // four dws
   localparam int LANES  = `RX_TKEEP_W;      // dws per FIFO word

   logic                  wr_act_q;   // payload beats belong to a write
   logic                  flush_q;    // stored half goes out alone this cycle
   logic [HALF_W-1:0]     hi_q;       // upper half of previous beat
   logic [`RX_LEN_W-1:0]  rem_q;      // dws from current word start to end
   logic                  wr_sop;
   logic                  wr_beat;
   logic [`RX_DATA_W-1:0] word;

   assign wr_sop  = hdr.sop && (hdr.desc.req_type == REQ_MEM_WR);
   assign wr_beat = hdr.beat && wr_act_q;

   //////////////////// flush decision
   // header alone always leaves dws 0..3 behind
   // a later last beat leaves its upper half only past eight dws
   assign wr_flush_o = hdr.last
                       && (wr_sop || (wr_beat && (rem_q > `RX_LEN_W'(LANES))));

   //////////////////// word assembly
   // lanes 0-3 come from the stored half, 4-7 from the low half of this beat
   always_comb begin
      if (flush_q) begin
         word = {{HALF_W{1'b0}}, hi_q};              // nothing follows
      end else begin
         word = {hdr.data[HALF_W-1:0], hi_q};
      end
      for (int i = 0; i < LANES; i++) begin
         if (`RX_LEN_W'(i) >= rem_q) begin
            word[i*`RX_DW_W +: `RX_DW_W] = '0;       // past the length
         end
      end
   end

   //////////////////// control
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_act_q     <= 1'b0;
         flush_q      <= 1'b0;
         fifo_wr_en_o <= 1'b0;
         pkt_done_o   <= 1'b0;
      end else begin
         flush_q      <= wr_flush_o;
         fifo_wr_en_o <= wr_beat | flush_q;         // every payload beat closes a word
         pkt_done_o   <= flush_q | (wr_beat & hdr.last & ~wr_flush_o);
         if (hdr.sop) begin
            wr_act_q <= wr_sop & ~hdr.last;          // single beat write needs no tracking
         end else if (hdr.last) begin
            wr_act_q <= 1'b0;
         end
      end
   end

   // payload and count
   always_ff @(posedge clk) begin
      if (wr_sop || wr_beat) begin
         hi_q <= hdr.data[`RX_DATA_W-1:HALF_W];      // start of the next word
      end
      if (wr_sop) begin
         rem_q <= hdr.desc.len;
      end else if (wr_beat) begin
         rem_q <= rem_q - `RX_LEN_W'(LANES);         // wraps on the last word, unused after
      end
      if (wr_beat || flush_q) begin
         fifo_wr_data_o <= word;
      end
   end

endmodule

`default_nettype wire

/* logic/throughput_meter.sv */
// WINDOW_CYCLES must be at least 2; a clear also drops a report due in the same cycle
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

module throughput_meter #(
   parameter int WINDOW_CYCLES = `RX_THRU_WINDOW
) (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    beat_i,         // accepted beat strobe
   input  wire                    thru_clear_i,
   output logic [`RX_CNT_W-1:0]   thru_count_o,
   output logic                   thru_valid_o
);

   localparam int WIN_W = $clog2(WINDOW_CYCLES);

   logic [WIN_W-1:0]     win_q;    // 0 .. WINDOW_CYCLES-1
   logic [`RX_CNT_W-1:0] cnt_q;    // beats so far in this window
   logic                 win_end;

   assign win_end = (win_q == WIN_W'(WINDOW_CYCLES - 1));

   //////////////////// window and beat counters
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         win_q        <= '0;
         cnt_q        <= '0;
         thru_valid_o <= 1'b0;
      end else if (thru_clear_i) begin
         win_q        <= '0;       // fresh window from here
         cnt_q        <= '0;
         thru_valid_o <= 1'b0;
      end else begin
         thru_valid_o <= win_end;
         win_q        <= win_end ? '0 : win_q + 1'b1;
         if (win_end) begin
            cnt_q <= '0;
         end else if (beat_i) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // last cycle of the window still counts
   always_ff @(posedge clk) begin
      if (win_end && !thru_clear_i) begin
         thru_count_o <= cnt_q + `RX_CNT_W'(beat_i);
      end
   end

endmodule

`default_nettype wire

/* logic/bmd_rx_engine.sv */
// completer-request side only; requester completions and tkeep are not looked at
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

module bmd_rx_engine
   import rx_pkg::*;
#(
   parameter int THRU_WINDOW = `RX_THRU_WINDOW
) (
   input  wire                    clk,
   input  wire                    rst_n,
   // CQ stream
   input  wire [`RX_DATA_W-1:0]   cq_tdata_i,
   input  wire                    cq_tvalid_i,
   input  wire                    cq_tlast_i,
   input  wire [`RX_TUSER_W-1:0]  cq_tuser_i,
   output logic                   cq_tready_o,
   // completion request towards transmit side
   input  wire                    compl_done_i,
   output logic                   req_compl_o,
   output logic [`RX_ADDR_W-1:0]  req_addr_o,
   output logic [`RX_RID_W-1:0]   req_rid_o,
   output logic [`RX_TAG_W-1:0]   req_tag_o,
   output logic [`RX_TC_W-1:0]    req_tc_o,
   output logic [`RX_ATTR_W-1:0]  req_attr_o,
   output logic [`RX_BE_W-1:0]    req_be_o,
   output logic [`RX_LEN_W-1:0]   req_len_o,
   // receive FIFO
   output logic [`RX_DATA_W-1:0]  fifo_wr_data_o,
   output logic                   fifo_wr_en_o,
   output logic                   pkt_done_o,
   // throughput
   input  wire                    thru_clear_i,
   output logic [`RX_CNT_W-1:0]   thru_count_o,
   output logic                   thru_valid_o
);

   logic     rd_hold;
   logic     wr_flush;
   cq_desc_t req_desc;

   cq_hdr_if hdr ();

   cq_decode u_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .cq_tdata_i  (cq_tdata_i),
      .cq_tvalid_i (cq_tvalid_i),
      .cq_tlast_i  (cq_tlast_i),
      .cq_tuser_i  (cq_tuser_i),
      .cq_tready_o (cq_tready_o),
      .rd_hold_i   (rd_hold),
      .wr_flush_i  (wr_flush),
      .hdr         (hdr.src)
   );

   mem_rd_request u_rd (
      .clk          (clk),
      .rst_n        (rst_n),
      .hdr          (hdr.rd),
      .compl_done_i (compl_done_i),
      .req_compl_o  (req_compl_o),
      .req_desc_o   (req_desc),
      .rd_hold_o    (rd_hold)
   );

   mem_wr_packer u_wr (
      .clk            (clk),
      .rst_n          (rst_n),
      .hdr            (hdr.wr),
      .fifo_wr_data_o (fifo_wr_data_o),
      .fifo_wr_en_o   (fifo_wr_en_o),
      .pkt_done_o     (pkt_done_o),
      .wr_flush_o     (wr_flush)
   );

   throughput_meter #(
      .WINDOW_CYCLES (THRU_WINDOW)
   ) u_thru (
      .clk          (clk),
      .rst_n        (rst_n),
      .beat_i       (hdr.sop | hdr.beat),   // header and payload beats alike
      .thru_clear_i (thru_clear_i),
      .thru_count_o (thru_count_o),
      .thru_valid_o (thru_valid_o)
   );

   // descriptor split for the transmit side
   assign req_addr_o = req_desc.addr;
   assign req_rid_o  = req_desc.rid;
   assign req_tag_o  = req_desc.tag;
   assign req_tc_o   = req_desc.tc;
   assign req_attr_o = req_desc.attr;
   assign req_be_o   = req_desc.be;
   assign req_len_o  = req_desc.len;

endmodule

`default_nettype wire

/* tests/bmd_rx_props.sv */
// bound into every bmd_rx_engine; checks start once rst_n is high, fail_cnt is read at the end
`timescale 1ns/1ps
`default_nettype none

module bmd_rx_props (
   input wire clk,
   input wire rst_n,
   input wire cq_tready_i,
   input wire req_compl_i,
   input wire compl_done_i,
   input wire fifo_wr_en_i,
   input wire wr_flush_i    // internal flush pulse of the packer
);

   int fail_cnt = 0;

   //////////////////// completion request
   no_wr_in_read: assert property (@(posedge clk) disable iff (!rst_n)
      !(fifo_wr_en_i && req_compl_i))
      else begin
         fail_cnt++;
         $error("FIFO write while a completion request is open");
      end

   compl_held: assert property (@(posedge clk) disable iff (!rst_n)
      req_compl_i && !compl_done_i |=> req_compl_i)   // level until done
      else begin
         fail_cnt++;
         $error("completion request dropped before done");
      end

   compl_falls: assert property (@(posedge clk) disable iff (!rst_n)
      req_compl_i && compl_done_i |=> !req_compl_i)
      else begin
         fail_cnt++;
         $error("completion request still high after done");
      end

   stall_in_read: assert property (@(posedge clk) disable iff (!rst_n)
      req_compl_i |-> !cq_tready_i)
      else begin
         fail_cnt++;
         $error("tready high while a read waits");
      end

   //////////////////// stream and FIFO
   ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> cq_tready_i)
      else begin
         fail_cnt++;
         $error("tready low right after reset");
      end

   ready_low_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
      wr_flush_i |=> !cq_tready_i)   // flush cycle is the one after the pulse
      else begin
         fail_cnt++;
         $error("tready high in a flush cycle");
      end

endmodule

bind bmd_rx_engine bmd_rx_props u_props (
   .clk          (clk),
   .rst_n        (rst_n),
   .cq_tready_i  (cq_tready_o),
   .req_compl_i  (req_compl_o),
   .compl_done_i (compl_done_i),
   .fifo_wr_en_i (fifo_wr_en_o),
   .wr_flush_i   (wr_flush)
);

`default_nettype wire

/* tests/tb_bmd_rx.sv */
// random traffic from a fixed seed; throughput checks assume the default window and no reads in flight
`timescale 1ns/1ps
`default_nettype none

`include "rx_params.svh"

module tb_bmd_rx
   import rx_pkg::*;
();

   localparam int N_SHORT   = 12;
   localparam int N_LONG    = 16;
   localparam int N_READ    = 8;
   localparam int N_IGNORE  = 8;
   localparam int PKT_COUNT = N_SHORT + N_LONG + N_READ + N_IGNORE;
   localparam int THRU_BUDGET = 2 * (3 * `RX_THRU_WINDOW + 100);   // two windows, with lead-in

   logic                   clk = 1'b0;
   logic                   rst_n;
   logic [`RX_DATA_W-1:0]  cq_tdata_i;
   logic                   cq_tvalid_i;
   logic                   cq_tlast_i;
   logic [`RX_TUSER_W-1:0] cq_tuser_i;
   logic                   cq_tready_o;
   logic                   compl_done_i;
   logic                   req_compl_o;
   logic [`RX_ADDR_W-1:0]  req_addr_o;
   logic [`RX_RID_W-1:0]   req_rid_o;
   logic [`RX_TAG_W-1:0]   req_tag_o;
   logic [`RX_TC_W-1:0]    req_tc_o;
   logic [`RX_ATTR_W-1:0]  req_attr_o;
   logic [`RX_BE_W-1:0]    req_be_o;
   logic [`RX_LEN_W-1:0]   req_len_o;
   logic [`RX_DATA_W-1:0]  fifo_wr_data_o;
   logic                   fifo_wr_en_o;
   logic                   pkt_done_o;
   logic                   thru_clear_i;
   logic [`RX_CNT_W-1:0]   thru_count_o;
   logic                   thru_valid_o;

   logic [31:0]           rng_state = 32'd869;
   logic [`RX_DATA_W-1:0] exp_words [$];   // model of the receive FIFO
   bit                    exp_done [$];    // pkt_done per expected word
   int                    n_checks   = 0;
   int                    n_errors   = 0;
   int                    beats_seen = 0;  // accepted beats, counted at negedge

   bmd_rx_engine bmd_rx_engine_i (.*);

   always #2 clk = ~clk;   // 4 ns

   //////////////////// helpers
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;            // back to the drive point
      end
   endtask

   task automatic compare_value(input logic [255:0] got, input logic [255:0] exp,
                                input string what);
      n_checks++;
      assert (got === exp) else begin
         n_errors++;
         $display("ERR %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic require(input bit ok, input string msg);
      n_checks++;
      assert (ok) else begin
         n_errors++;
         $display("check failed at %0d ns: %s", $time, msg);
      end
   endtask

   // one beat, random idle cycles first, held until tready
   task automatic send_beat(input logic [255:0] data, input bit last, input logic [7:0] be);
      int gap;
      bit rdy;
      gap = (next_rand() % 4 == 0) ? 1 + int'(next_rand() % 3) : 0;
      wait_cycles(gap);
      cq_tdata_i  = data;
      cq_tlast_i  = last;
      cq_tuser_i  = '0;
      cq_tuser_i[`RX_BE_MSB:`RX_BE_LSB] = be;
      cq_tvalid_i = 1'b1;
      do begin
         rdy = cq_tready_o;   // register, stable until the next edge
         wait_cycles(1);
      end while (!rdy);
      cq_tvalid_i = 1'b0;
   endtask

   //////////////////// packets
   task automatic send_write(input int len);
      logic [31:0]  strm [0:31];   // descriptor dws 0..3, payload from dw 4
      logic [127:0] h;
      logic [255:0] word;
      int           nb;
      int           nw;
      for (int s = 0; s < 32; s++) begin
         strm[s] = next_rand();    // lanes past the length stay random
      end
      h = {strm[3], strm[2], strm[1], strm[0]};
      h[`RX_LEN_MSB:`RX_LEN_LSB]   = `RX_LEN_W'(len);
      h[`RX_TYPE_MSB:`RX_TYPE_LSB] = REQ_MEM_WR;
      for (int k = 0; k < 4; k++) begin
         strm[k] = h[k*32 +: 32];
      end
      nw = (len + 7) / 8;
      for (int w = 0; w < nw; w++) begin   // payload dw i at word i/8, lane i%8
         word = '0;
         for (int j = 0; j < 8; j++) begin
            if (w * 8 + j < len) begin
               word[j*32 +: 32] = strm[4 + w*8 + j];
            end
         end
         exp_words.push_back(word);
         exp_done.push_back(w == nw - 1);
      end
      nb = (len + 11) / 8;
      for (int b = 0; b < nb; b++) begin
         for (int l = 0; l < 8; l++) begin
            word[l*32 +: 32] = strm[b*8 + l];
         end
         send_beat(word, b == nb - 1, 8'(next_rand()));
      end
   endtask

   // reads and unknown types; only a one dw read gets a request
   task automatic send_request(input logic [3:0] rtype, input int len, input int nb);
      logic [255:0] data;
      logic [7:0]   be;
      int           hold;
      for (int k = 0; k < 8; k++) begin
         data[k*32 +: 32] = next_rand();
      end
      data[`RX_LEN_MSB:`RX_LEN_LSB]   = `RX_LEN_W'(len);
      data[`RX_TYPE_MSB:`RX_TYPE_LSB] = rtype;
      be = 8'(next_rand());
      for (int b = 0; b < nb; b++) begin
         send_beat(data, b == nb - 1, be);
      end
      if (rtype == REQ_MEM_RD && len == 1) begin
         require(req_compl_o === 1'b1, "no completion request after a one DW read");
         compare_value(req_addr_o, data[`RX_ADDR_MSB:`RX_ADDR_LSB], "req_addr_o");
         compare_value(req_rid_o, data[`RX_RID_MSB:`RX_RID_LSB], "req_rid_o");
         compare_value(req_tag_o, data[`RX_TAG_MSB:`RX_TAG_LSB], "req_tag_o");
         compare_value(req_tc_o, data[`RX_TC_MSB:`RX_TC_LSB], "req_tc_o");
         compare_value(req_attr_o, data[`RX_ATTR_MSB:`RX_ATTR_LSB], "req_attr_o");
         compare_value(req_be_o, be, "req_be_o");
         compare_value(req_len_o, 1, "req_len_o");
         hold = int'(next_rand() % 10);   // transmit side takes its time
         repeat (hold) begin
            require(req_compl_o && !cq_tready_o, "request dropped or tready high too early");
            wait_cycles(1);
         end
         compl_done_i = 1'b1;
         wait_cycles(1);
         compl_done_i = 1'b0;
         require(!req_compl_o && cq_tready_o, "request or stall still up after done");
      end else begin
         wait_cycles(3);
         require(!req_compl_o, "completion request for an ignored packet");
      end
   endtask

   //////////////////// throughput
   task automatic measure_window();
      bit stop;
      int waited;
      int base;
      stop = 1'b0;
      fork
         while (!stop) begin
            send_write(1 + int'(next_rand() % 20));
         end
         begin
            wait_cycles(5 + int'(next_rand() % 40));   // beats before the clear
            thru_clear_i = 1'b1;
            wait_cycles(1);
            thru_clear_i = 1'b0;
            base = beats_seen;   // window starts with the next edge
            waited = 0;
            while (!thru_valid_o && waited < 2 * `RX_THRU_WINDOW) begin
               wait_cycles(1);
               waited++;
            end
            require(thru_valid_o === 1'b1, "no throughput report after the clear");
            compare_value(waited, `RX_THRU_WINDOW, "cycles from clear to report");
            compare_value(thru_count_o, beats_seen - base, "thru_count_o");
            stop = 1'b1;
         end
      join
   endtask

   task automatic drain();
      int c;
      c = 0;
      while (exp_words.size() != 0 && c < 16) begin
         wait_cycles(1);
         c++;
      end
      require(exp_words.size() == 0, "expected FIFO words never arrived");
   endtask

   //////////////////// monitors
   always @(negedge clk) begin
      if (rst_n && cq_tvalid_i && cq_tready_o) beats_seen++;   // taken at the next edge
      if (rst_n && fifo_wr_en_o) begin
         if (exp_words.size() == 0) begin
            require(1'b0, "FIFO write with no word expected");
         end else begin
            compare_value(fifo_wr_data_o, exp_words.pop_front(), "fifo_wr_data_o");
            compare_value(pkt_done_o, exp_done.pop_front(), "pkt_done_o");
         end
      end else if (rst_n && pkt_done_o) begin
         require(1'b0, "pkt_done without a FIFO write");
      end
   end

   initial begin
      repeat (PKT_COUNT * 1000 + THRU_BUDGET) @(posedge clk);
      $display("timeout: the tests did not finish within the cycle budget");
      $display("*** TEST FAILED ***");
      $finish;
   end

   //////////////////// test sequence
   initial begin
      int mark;
      rst_n        = 1'b0;
      cq_tdata_i   = '0;
      cq_tvalid_i  = 1'b0;
      cq_tlast_i   = 1'b0;
      cq_tuser_i   = '0;
      compl_done_i = 1'b0;
      thru_clear_i = 1'b0;
      repeat (8) @(posedge clk);
      #1 rst_n = 1'b1;
      wait_cycles(2);

      mark = n_errors;
      for (int i = 0; i < N_SHORT; i++) send_write(1 + int'(next_rand() % 4));
      drain();
      $display("test 1 short writes: %0d errors", n_errors - mark);

      mark = n_errors;
      for (int i = 0; i < N_LONG; i++) send_write(5 + int'(next_rand() % 16));
      drain();
      $display("test 2 long writes: %0d errors", n_errors - mark);

      mark = n_errors;
      for (int i = 0; i < N_READ; i++) send_request(REQ_MEM_RD, 1, 1);
      $display("test 3 one DW reads: %0d errors", n_errors - mark);

      mark = n_errors;
      for (int i = 0; i < N_IGNORE; i++) begin
         if (i % 2 == 0) send_request(REQ_MEM_RD, 2 + int'(next_rand() % 30), 1);
         else send_request(4'(2 + next_rand() % 14), 8, 1 + int'(next_rand() % 2));
      end
      drain();
      $display("test 4 ignored requests: %0d errors", n_errors - mark);

      mark = n_errors;
      measure_window();
      measure_window();
      drain();
      $display("test 5 throughput: %0d errors", n_errors - mark);

      $display("5 tests, %0d checks, %0d errors, %0d assertion failures",
               n_checks, n_errors, bmd_rx_engine_i.u_props.fail_cnt);
      if (n_errors == 0 && bmd_rx_engine_i.u_props.fail_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+logic
logic/rx_pkg.sv
logic/cq_hdr_if.sv
logic/cq_decode.sv
logic/mem_rd_request.sv
logic/mem_wr_packer.sv
logic/throughput_meter.sv
logic/bmd_rx_engine.sv
tests/bmd_rx_props.sv
tests/tb_bmd_rx.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --assert -Wno-fatal -j 0
TOP      := tb_bmd_rx
FILELIST := sources.f
RUN_ARGS := +verilator+error+limit+1000
PASS_MSG := *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
